// File: rv_exec.f
design/rv_exec_pkg.sv
design/exu_alu.sv
design/exu_branch.sv
design/exu_csr.sv
design/exu_stage.sv
design/data_mem.sv
design/exec_top.sv
tests/clk_gen.sv
tests/exec_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= rv_exec.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/exec_trace.txt
# pc inst imm op1 op2 opj alu_op rd flags(ren wen jen ben sys csr_wen ecall mret ebreak) hold
# expected: rd reg_wdata redirect npc ebreak; all hex except flags, which are binary
100 0 0 5 7 0 0 1 000000000 0   1 c 0 0 0
104 0 0 3 5 0 1 2 000000000 1   2 fffffffe 0 0 0
108 0 0 1 24 0 2 3 000000000 0   3 10 0 0 0
10c 0 0 80000000 4 0 7 4 000000000 0   4 f8000000 0 0 0
110 0 0 80000000 4 0 6 5 000000000 0   5 8000000 0 0 0
114 0 0 ffffffff 1 0 3 6 000000000 0   6 1 0 0 0
118 0 0 ffffffff 1 0 4 7 000000000 2   7 0 0 0 0
11c 0 0 5 5 0 a 8 000000000 0   8 1 0 0 0
120 0 0 ffffffff 5 0 b 9 000000000 0   9 0 0 0 0
124 0 0 a5a5a5a5 ffff0000 0 5 a 000000000 0   a 5a5aa5a5 0 0 0
128 0 0 f0 f 0 8 b 000000000 0   b ff 0 0 0
12c 0 0 f0 3c 0 9 c 000000000 1   c 30 0 0 0
130 0 0 1 2 0 0 0 000000000 0   0 0 0 0 0
134 0 20 7 7 134 1 0 000100000 0   0 0 1 154 0
138 0 10 7 7 138 5 0 000100000 0   0 0 0 148 0
13c 0 fffffff0 ffffffff 0 13c 3 0 000100000 1   0 0 1 12c 0
140 0 40 140 4 140 0 1 001000000 0   1 144 1 180 0
144 0 8 0 deadbeef 40 0 0 010000000 0   0 0 0 48 0
148 0 4 0 0 44 0 5 100000000 2   5 deadbeef 0 48 0
14c 1000 305 200 0 0 0 1 000011000 0   1 0 0 305 0
150 2000 305 3 0 0 0 2 000011000 0   2 200 0 305 0
154 3000 305 3 0 0 0 3 000011000 1   3 203 0 305 0
158 5000 300 8 0 0 0 4 000011000 0   4 0 0 300 0
15c 6000 300 3 0 0 0 5 000011000 0   5 8 0 300 0
160 7000 300 9 0 0 0 6 000011000 0   6 b 0 300 0
164 2000 305 0 0 0 0 7 000011000 0   7 200 0 305 0
168 0 0 0 0 0 0 0 000010100 1   0 0 1 200 0
16c 2000 341 0 0 0 0 1 000011000 0   1 168 0 341 0
170 2000 342 0 0 0 0 2 000011000 0   2 b 0 342 0
174 0 300 0 0 0 0 0 000011010 0   0 0 1 168 0
178 2000 300 0 0 0 0 3 000011000 2   3 82 0 300 0
17c 0 0 0 0 0 0 0 000010001 0   0 0 0 0 1

// File: tests/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tb;

  localparam int    MEM_DEPTH = 256;
  localparam int    MEM_LAT   = 2;
  localparam int    TIMEOUT   = 50;  // Cycles per wait.
  localparam string TRACE     = "tests/exec_trace.txt";

  logic                  clk;
  logic                  rst;
  rv_exec_pkg::word_t    pc_i, imm_i, op1_i, op2_i, opj_i;
  rv_exec_pkg::inst_t    inst_i;
  rv_exec_pkg::alu_op_e  alu_op_i;
  rv_exec_pkg::reg_idx_t rd_i;
  logic ren_i, wen_i, jen_i, ben_i, system_i, csr_wen_i, ecall_i, mret_i, ebreak_i;
  logic prev_valid_i, next_ready_i;
  logic                  valid_o, ready_o, redirect_o, ebreak_o;
  rv_exec_pkg::reg_idx_t rd_o;
  rv_exec_pkg::word_t    reg_wdata_o, npc_o, pc_o;

  // One trace line.
  logic [31:0] tr_pc, tr_inst, tr_imm, tr_op1, tr_op2, tr_opj;
  logic [3:0]  tr_alu, tr_rd, tr_hold;
  logic [8:0]  tr_flags;
  logic [3:0]  exp_rd;
  logic [31:0] exp_wdata, exp_npc;
  logic        exp_redirect, exp_ebreak;

  int          entry, checks, errors, entry_err;
  bit          timed_out, file_bad;
  logic [31:0] rng;

  clk_gen #(.PERIOD_NS(100)) u_clk_gen (.clk_o(clk));

  exec_top #(
    .MEM_DEPTH (MEM_DEPTH),
    .MEM_LAT   (MEM_LAT)
  ) u_exec_top (
    .clk          (clk),
    .rst          (rst),
    .pc_i         (pc_i),
    .inst_i       (inst_i),
    .imm_i        (imm_i),
    .op1_i        (op1_i),
    .op2_i        (op2_i),
    .opj_i        (opj_i),
    .alu_op_i     (alu_op_i),
    .rd_i         (rd_i),
    .ren_i        (ren_i),
    .wen_i        (wen_i),
    .jen_i        (jen_i),
    .ben_i        (ben_i),
    .system_i     (system_i),
    .csr_wen_i    (csr_wen_i),
    .ecall_i      (ecall_i),
    .mret_i       (mret_i),
    .ebreak_i     (ebreak_i),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .valid_o      (valid_o),
    .ready_o      (ready_o),
    .rd_o         (rd_o),
    .reg_wdata_o  (reg_wdata_o),
    .npc_o        (npc_o),
    .redirect_o   (redirect_o),
    .ebreak_o     (ebreak_o),
    .pc_o         (pc_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ####################
  // Checks
  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error: entry %0d %s = 0x%08h, expected 0x%08h", entry, name, got, exp);
      errors++;
      entry_err++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error: entry %0d %s = 0x%0h, expected 0x%0h", entry, name, got, exp);
      errors++;
      entry_err++;
    end
  endtask

  // ####################
  // Stimulus
  task automatic init_inputs();
    rst          = 1'b1;
    pc_i         = '0;
    inst_i       = '0;
    imm_i        = '0;
    op1_i        = '0;
    op2_i        = '0;
    opj_i        = '0;
    alu_op_i     = rv_exec_pkg::ALU_ADD;
    rd_i         = '0;
    {ren_i, wen_i, jen_i, ben_i, system_i, csr_wen_i, ecall_i, mret_i, ebreak_i} = '0;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b1;
  endtask

  task automatic drive_entry();
    pc_i     = tr_pc;
    inst_i   = tr_inst;
    imm_i    = tr_imm;
    op1_i    = tr_op1;
    op2_i    = tr_op2;
    opj_i    = tr_opj;
    alu_op_i = rv_exec_pkg::alu_op_e'(tr_alu);
    rd_i     = tr_rd;
    {ren_i, wen_i, jen_i, ben_i, system_i, csr_wen_i, ecall_i, mret_i, ebreak_i} = tr_flags;
    prev_valid_i = 1'b1;
  endtask

  // Offers an unrelated operation that must not be taken.
  task automatic drive_junk();
    rng   = xorshift32(rng);
    pc_i  = rng;
    rng   = xorshift32(rng);
    op1_i = rng;
    rng   = xorshift32(rng);
    op2_i = rng;
    rd_i  = rng[3:0];
    {ren_i, wen_i, jen_i, ben_i, system_i, csr_wen_i, ecall_i, mret_i, ebreak_i} = '0;
    prev_valid_i = 1'b1;
  endtask

  task automatic check_reset();
    entry_err = 0;
    check_bit("valid_o", valid_o, 1'b0);
    check_bit("ready_o", ready_o, 1'b1);
    check_bit("redirect_o", redirect_o, 1'b0);
    check_bit("ebreak_o", ebreak_o, 1'b0);
    $display("reset: %s", (entry_err == 0) ? "ok" : "FAILED");
  endtask

  task automatic run_entry();
    int          cnt;
    int          stall;
    int          exp_wait;
    logic [31:0] snap_wdata;
    logic [3:0]  snap_rd;
    bit          is_mem;
    entry_err = 0;
    is_mem    = tr_flags[8] | tr_flags[7];
    exp_wait  = is_mem ? MEM_LAT + 2 : 0;  // Memory ops answer after the latency.
    drive_entry();
    cnt = 0;
    while (!ready_o && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!ready_o) begin
      $display("Timeout: entry %0d was never accepted within %0d cycles", entry, TIMEOUT);
      timed_out = 1'b1;
      return;
    end
    @(posedge clk);  // Acceptance edge.
    @(negedge clk);
    drive_junk();
    cnt = 0;
    while (!valid_o && cnt < TIMEOUT) begin
      check_bit("ready_o while memory busy", ready_o, 1'b0);
      @(negedge clk);
      cnt++;
    end
    if (!valid_o) begin
      $display("Timeout: entry %0d, valid_o did not rise within %0d cycles", entry, TIMEOUT);
      timed_out = 1'b1;
      return;
    end
    checks++;
    assert (cnt == exp_wait) else begin
      $display("Entry %0d: valid_o came after %0d extra cycles instead of %0d",
               entry, cnt, exp_wait);
      errors++;
      entry_err++;
    end
    next_ready_i = 1'b0;
    snap_wdata   = reg_wdata_o;
    snap_rd      = rd_o;
    rng          = xorshift32(rng);
    stall        = int'(tr_hold) + int'(rng[1:0]);
    repeat (stall) begin
      @(negedge clk);
      drive_junk();
      check_bit("valid_o under back-pressure", valid_o, 1'b1);
      check_bit("ready_o under back-pressure", ready_o, 1'b0);
      check_word("reg_wdata_o under back-pressure", reg_wdata_o, snap_wdata);
      check_word("rd_o under back-pressure", {28'h0, rd_o}, {28'h0, snap_rd});
    end
    check_bit("valid_o", valid_o, 1'b1);
    check_word("rd_o", {28'h0, rd_o}, {28'h0, exp_rd});
    check_word("reg_wdata_o", reg_wdata_o, exp_wdata);
    check_bit("redirect_o", redirect_o, exp_redirect);
    check_word("npc_o", npc_o, exp_npc);
    check_bit("ebreak_o", ebreak_o, exp_ebreak);
    check_word("pc_o", pc_o, tr_pc);
    next_ready_i = 1'b1;
    prev_valid_i = 1'b0;
    @(posedge clk);  // Retire edge.
    @(negedge clk);
    check_bit("valid_o after retire", valid_o, 1'b0);
    $display("entry %0d pc 0x%0h stall %0d: %s", entry, tr_pc, stall,
             (entry_err == 0) ? "ok" : "FAILED");
  endtask

  // ####################
  // Main sequence
  initial begin
    int    fd;
    int    n;
    int    got;
    string line;
    byte   c;
    entry     = 0;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    file_bad  = 1'b0;
    rng       = 32'd20;
    init_inputs();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_reset();
    fd = $fopen(TRACE, "r");
    if (fd == 0) begin
      $display("Could not open the trace file %s", TRACE);
      file_bad = 1'b1;
    end else begin
      n = $fgets(line, fd);
      while (n != 0 && !timed_out) begin
        c = line.getc(0);
        if (c != "#" && c != 8'h0a && c != " ") begin
          got = $sscanf(line, "%h %h %h %h %h %h %h %h %b %h %h %h %h %h %h",
                        tr_pc, tr_inst, tr_imm, tr_op1, tr_op2, tr_opj, tr_alu, tr_rd,
                        tr_flags, tr_hold, exp_rd, exp_wdata, exp_redirect, exp_npc,
                        exp_ebreak);
          if (got != 15) begin
            $display("Trace line could not be parsed: %s", line);
            errors++;
          end else begin
            entry++;
            run_entry();
          end
        end
        n = $fgets(line, fd);
      end
      $fclose(fd);
    end
    $display("entries %0d, checks %0d, errors %0d", entry, checks, errors);
    if (errors == 0 && !timed_out && !file_bad && entry > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: design/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top #(
  parameter int MEM_DEPTH = 256,
  parameter int MEM_LAT   = 2
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire rv_exec_pkg::word_t    pc_i,
  input  wire rv_exec_pkg::inst_t    inst_i,
  input  wire rv_exec_pkg::word_t    imm_i,
  input  wire rv_exec_pkg::word_t    op1_i,
  input  wire rv_exec_pkg::word_t    op2_i,
  input  wire rv_exec_pkg::word_t    opj_i,
  input  wire rv_exec_pkg::alu_op_e  alu_op_i,
  input  wire rv_exec_pkg::reg_idx_t rd_i,
  input  wire logic                  ren_i,
  input  wire logic                  wen_i,
  input  wire logic                  jen_i,
  input  wire logic                  ben_i,
  input  wire logic                  system_i,
  input  wire logic                  csr_wen_i,
  input  wire logic                  ecall_i,
  input  wire logic                  mret_i,
  input  wire logic                  ebreak_i,
  input  wire logic                  prev_valid_i,
  input  wire logic                  next_ready_i,
  output logic                       valid_o,
  output logic                       ready_o,
  output rv_exec_pkg::reg_idx_t      rd_o,
  output rv_exec_pkg::word_t         reg_wdata_o,
  output rv_exec_pkg::word_t         npc_o,
  output logic                       redirect_o,
  output logic                       ebreak_o,
  output rv_exec_pkg::word_t         pc_o
);

  logic               mem_avalid, mem_wen, mem_rvalid, mem_wready;
  rv_exec_pkg::word_t mem_addr, mem_wdata, mem_rdata;

  exu_stage u_stage (
    .clk          (clk),
    .rst          (rst),
    .pc_i         (pc_i),
    .inst_i       (inst_i),
    .imm_i        (imm_i),
    .op1_i        (op1_i),
    .op2_i        (op2_i),
    .opj_i        (opj_i),
    .alu_op_i     (alu_op_i),
    .rd_i         (rd_i),
    .ren_i        (ren_i),
    .wen_i        (wen_i),
    .jen_i        (jen_i),
    .ben_i        (ben_i),
    .system_i     (system_i),
    .csr_wen_i    (csr_wen_i),
    .ecall_i      (ecall_i),
    .mret_i       (mret_i),
    .ebreak_i     (ebreak_i),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .mem_rdata_i  (mem_rdata),
    .mem_rvalid_i (mem_rvalid),
    .mem_wready_i (mem_wready),
    .mem_avalid_o (mem_avalid),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_wen_o    (mem_wen),
    .valid_o      (valid_o),
    .ready_o      (ready_o),
    .rd_o         (rd_o),
    .reg_wdata_o  (reg_wdata_o),
    .npc_o        (npc_o),
    .redirect_o   (redirect_o),
    .ebreak_o     (ebreak_o),
    .pc_o         (pc_o)
  );

  data_mem #(
    .MEM_DEPTH (MEM_DEPTH),
    .MEM_LAT   (MEM_LAT)
  ) u_mem (
    .clk      (clk),
    .rst      (rst),
    .avalid_i (mem_avalid),
    .wen_i    (mem_wen),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .rdata_o  (mem_rdata),
    .rvalid_o (mem_rvalid),
    .wready_o (mem_wready)
  );

endmodule

`default_nettype wire

// File: design/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
  parameter int MEM_DEPTH = 256,
  parameter int MEM_LAT   = 2
) (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               avalid_i,
  input  wire logic               wen_i,
  input  wire rv_exec_pkg::word_t addr_i,
  input  wire rv_exec_pkg::word_t wdata_i,
  output rv_exec_pkg::word_t      rdata_o,
  output logic                    rvalid_o,
  output logic                    wready_o
);

  localparam int IDX_W = $clog2(MEM_DEPTH);
  localparam int CNT_W = $clog2(MEM_LAT + 1);

  rv_exec_pkg::word_t mem_q [MEM_DEPTH] = '{default: '0};
  logic [IDX_W-1:0]   idx;
  logic [CNT_W-1:0]   cnt_q;
  logic               busy_q, avalid_q;

  assign idx = addr_i[IDX_W-1:0];

  // ####################
  // Latency countdown
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q   <= 1'b0;
      avalid_q <= 1'b0;
      cnt_q    <= '0;
      rvalid_o <= 1'b0;
      wready_o <= 1'b0;
    end else begin
      avalid_q <= avalid_i;
      rvalid_o <= 1'b0;
      wready_o <= 1'b0;
      if (avalid_i && !avalid_q && !busy_q) begin
        busy_q <= 1'b1;  // New request.
        cnt_q  <= CNT_W'(MEM_LAT - 1);
      end else if (busy_q) begin
        if (cnt_q == '0) begin
          busy_q   <= 1'b0;
          rvalid_o <= ~wen_i;
          wready_o <= wen_i;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy_q && cnt_q == '0) begin
      if (wen_i) begin
        mem_q[idx] <= wdata_i;
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

  a_strobe_needs_req: assert property (@(posedge clk) disable iff (rst)
    (rvalid_o || wready_o) |-> avalid_i);

endmodule

`default_nettype wire

// File: design/exu_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exu_stage (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire rv_exec_pkg::word_t    pc_i,
  input  wire rv_exec_pkg::inst_t    inst_i,
  input  wire rv_exec_pkg::word_t    imm_i,
  input  wire rv_exec_pkg::word_t    op1_i,
  input  wire rv_exec_pkg::word_t    op2_i,
  input  wire rv_exec_pkg::word_t    opj_i,
  input  wire rv_exec_pkg::alu_op_e  alu_op_i,
  input  wire rv_exec_pkg::reg_idx_t rd_i,
  input  wire logic                  ren_i,
  input  wire logic                  wen_i,
  input  wire logic                  jen_i,
  input  wire logic                  ben_i,
  input  wire logic                  system_i,
  input  wire logic                  csr_wen_i,
  input  wire logic                  ecall_i,
  input  wire logic                  mret_i,
  input  wire logic                  ebreak_i,
  input  wire logic                  prev_valid_i,
  input  wire logic                  next_ready_i,
  input  wire rv_exec_pkg::word_t    mem_rdata_i,
  input  wire logic                  mem_rvalid_i,
  input  wire logic                  mem_wready_i,
  output logic                       mem_avalid_o,
  output rv_exec_pkg::word_t         mem_addr_o,
  output rv_exec_pkg::word_t         mem_wdata_o,
  output logic                       mem_wen_o,
  output logic                       valid_o,
  output logic                       ready_o,
  output rv_exec_pkg::reg_idx_t      rd_o,
  output rv_exec_pkg::word_t         reg_wdata_o,
  output rv_exec_pkg::word_t         npc_o,
  output logic                       redirect_o,
  output logic                       ebreak_o,
  output rv_exec_pkg::word_t         pc_o
);

  rv_exec_pkg::exu_state_e state_q;
  rv_exec_pkg::word_t      pc_q, imm_q, src1_q, src2_q, opj_q, load_data_q;
  rv_exec_pkg::inst_t      inst_q;
  rv_exec_pkg::alu_op_e    alu_op_q;
  rv_exec_pkg::reg_idx_t   rd_q;
  logic ren_q, wen_q, jen_q, ben_q, system_q, csr_wen_q, ecall_q, mret_q, ebreak_q;
  logic valid_q, avalid_q;
  logic accept, retire, mem_done;
  rv_exec_pkg::word_t      acc_addr, alu_res, csr_rdata, csr_wdata, mtvec, mepc, br_npc;
  logic                    br_redirect;

  assign ready_o  = (state_q == rv_exec_pkg::IDLE) & next_ready_i;
  assign accept   = prev_valid_i & ready_o;
  assign retire   = valid_q & next_ready_i;
  assign mem_done = (state_q == rv_exec_pkg::WAIT_MEM) &
                    ((wen_q & mem_wready_i) | (ren_q & mem_rvalid_i));
  assign acc_addr = opj_q + imm_q;

  // ####################
  // Pipeline payload
  always_ff @(posedge clk) begin
    if (accept) begin
      pc_q     <= pc_i;
      inst_q   <= inst_i;
      imm_q    <= imm_i;
      src1_q   <= op1_i;
      src2_q   <= op2_i;
      opj_q    <= opj_i;
      alu_op_q <= alu_op_i;
    end
    if (mem_done && ren_q) begin
      load_data_q <= mem_rdata_i;
    end
  end

  // ####################
  // Control and memory FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= rv_exec_pkg::IDLE;
      valid_q   <= 1'b0;
      avalid_q  <= 1'b0;
      rd_q      <= '0;
      ren_q     <= 1'b0;
      wen_q     <= 1'b0;
      jen_q     <= 1'b0;
      ben_q     <= 1'b0;
      system_q  <= 1'b0;
      csr_wen_q <= 1'b0;
      ecall_q   <= 1'b0;
      mret_q    <= 1'b0;
      ebreak_q  <= 1'b0;
    end else begin
      if (retire) begin
        valid_q <= 1'b0;
      end
      if (accept) begin
        rd_q      <= rd_i;
        ren_q     <= ren_i;
        wen_q     <= wen_i;
        jen_q     <= jen_i;
        ben_q     <= ben_i;
        system_q  <= system_i;
        csr_wen_q <= csr_wen_i;
        ecall_q   <= ecall_i;
        mret_q    <= mret_i;
        ebreak_q  <= ebreak_i;
        valid_q   <= ~(ren_i | wen_i);  // Memory ops wait for the answer.
        if (ren_i || wen_i) begin
          state_q  <= rv_exec_pkg::WAIT_MEM;
          avalid_q <= 1'b1;
        end
      end
      if (mem_done) begin
        state_q  <= rv_exec_pkg::IDLE;
        avalid_q <= 1'b0;
        valid_q  <= 1'b1;
      end
    end
  end

  exu_alu u_alu (
    .src1_i (src1_q),
    .src2_i (src2_q),
    .op_i   (alu_op_q),
    .res_o  (alu_res)
  );

  exu_branch u_branch (
    .ben_i       (ben_q),
    .jen_i       (jen_q),
    .ecall_i     (ecall_q),
    .mret_i      (mret_q),
    .system_i    (system_q),
    .alu_op_i    (alu_op_q),
    .alu_res_i   (alu_res),
    .src1_i      (src1_q),
    .funct3_i    (inst_q[14:12]),
    .csr_rdata_i (csr_rdata),
    .mtvec_i     (mtvec),
    .mepc_i      (mepc),
    .target_i    (acc_addr),
    .redirect_o  (br_redirect),
    .npc_o       (br_npc),
    .csr_wdata_o (csr_wdata)
  );

  exu_csr u_csr (
    .clk     (clk),
    .rst     (rst),
    .wen_i   (csr_wen_q),
    .fire_i  (retire),  // CSRs update once, at retire.
    .ecall_i (ecall_q),
    .addr_i  (imm_q[11:0]),
    .wdata_i (csr_wdata),
    .pc_i    (pc_q),
    .rdata_o (csr_rdata),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  assign mem_avalid_o = avalid_q;
  assign mem_addr_o   = {2'b00, acc_addr[31:2]};  // Word index.
  assign mem_wdata_o  = src2_q;
  assign mem_wen_o    = wen_q;
  assign valid_o      = valid_q;
  assign rd_o         = rd_q;
  assign reg_wdata_o  = (rd_q == '0) ? '0 :
                        ren_q ? load_data_q :
                        system_q ? csr_rdata : alu_res;
  assign npc_o        = br_npc;
  assign redirect_o   = br_redirect & valid_q;
  assign ebreak_o     = ebreak_q & valid_q;
  assign pc_o         = pc_q;

  // Neither a request nor a memory answer while idle.
  a_no_avalid_idle: assert property (@(posedge clk) disable iff (rst)
    (state_q == rv_exec_pkg::IDLE) |-> !(mem_avalid_o || mem_rvalid_i || mem_wready_i));

  // Held result must not move under back-pressure.
  a_hold_result: assert property (@(posedge clk) disable iff (rst)
    (valid_o && !next_ready_i) |=> (valid_o && $stable(reg_wdata_o)));

endmodule

`default_nettype wire

// File: design/exu_csr.sv
`timescale 1ns/1ps
`default_nettype none

module exu_csr (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  wen_i,
  input  wire logic                  fire_i,
  input  wire logic                  ecall_i,
  input  wire rv_exec_pkg::csr_addr_t addr_i,
  input  wire rv_exec_pkg::word_t    wdata_i,
  input  wire rv_exec_pkg::word_t    pc_i,
  output rv_exec_pkg::word_t         rdata_o,
  output rv_exec_pkg::word_t         mtvec_o,
  output rv_exec_pkg::word_t         mepc_o
);

  rv_exec_pkg::word_t mstatus_q;
  rv_exec_pkg::word_t mtvec_q;
  rv_exec_pkg::word_t mepc_q;
  rv_exec_pkg::word_t mcause_q;

  // ####################
  // Read port
  always_comb begin
    case (addr_i)
      rv_exec_pkg::CSR_MSTATUS: begin
        rdata_o = mstatus_q;
      end
      rv_exec_pkg::CSR_MTVEC: begin
        rdata_o = mtvec_q;
      end
      rv_exec_pkg::CSR_MEPC: begin
        rdata_o = mepc_q;
      end
      rv_exec_pkg::CSR_MCAUSE: begin
        rdata_o = mcause_q;
      end
      default: begin
        rdata_o = '0;  // Unimplemented CSR.
      end
    endcase
  end

  // ####################
  // Write port and trap update
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (fire_i) begin
      if (wen_i) begin
        case (addr_i)
          rv_exec_pkg::CSR_MSTATUS: mstatus_q <= wdata_i;
          rv_exec_pkg::CSR_MTVEC:   mtvec_q   <= wdata_i;
          rv_exec_pkg::CSR_MEPC:    mepc_q    <= wdata_i;
          rv_exec_pkg::CSR_MCAUSE:  mcause_q  <= wdata_i;
          default: ;
        endcase
      end
      if (ecall_i) begin
        mepc_q   <= pc_i;  // Trap return address.
        mcause_q <= rv_exec_pkg::CAUSE_ECALL_M;
      end
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  // Decode must point an ecall's CSR write at mcause only.
  a_ecall_wr_mcause: assert property (@(posedge clk) disable iff (rst)
    (fire_i && ecall_i && wen_i) |-> (addr_i == rv_exec_pkg::CSR_MCAUSE));

endmodule

`default_nettype wire

// File: design/exu_branch.sv
`timescale 1ns/1ps
`default_nettype none

module exu_branch (
  input  wire logic                 ben_i,
  input  wire logic                 jen_i,
  input  wire logic                 ecall_i,
  input  wire logic                 mret_i,
  input  wire logic                 system_i,
  input  wire rv_exec_pkg::alu_op_e alu_op_i,
  input  wire rv_exec_pkg::word_t   alu_res_i,
  input  wire rv_exec_pkg::word_t   src1_i,
  input  wire logic [2:0]           funct3_i,
  input  wire rv_exec_pkg::word_t   csr_rdata_i,
  input  wire rv_exec_pkg::word_t   mtvec_i,
  input  wire rv_exec_pkg::word_t   mepc_i,
  input  wire rv_exec_pkg::word_t   target_i,
  output logic                      redirect_o,
  output rv_exec_pkg::word_t        npc_o,
  output rv_exec_pkg::word_t        csr_wdata_o
);

  localparam rv_exec_pkg::word_t MPIE_MASK = 32'h0000_0080;

  // ####################
  // Branch decision
  always_comb begin
    if (ben_i) begin
      case (alu_op_i)
        rv_exec_pkg::ALU_SUB: redirect_o = ~|alu_res_i;  // beq/bne via SUB.
        rv_exec_pkg::ALU_XOR,
        rv_exec_pkg::ALU_SLT,
        rv_exec_pkg::ALU_SLTU,
        rv_exec_pkg::ALU_SLE,
        rv_exec_pkg::ALU_SLEU: redirect_o = |alu_res_i;
        default: redirect_o = 1'b0;
      endcase
    end else begin
      redirect_o = ecall_i | mret_i | jen_i;
    end
  end

  assign npc_o = ecall_i ? mtvec_i : (mret_i ? mepc_i : target_i);

  // ####################
  // CSR write data
  always_comb begin
    csr_wdata_o = '0;
    if (system_i) begin
      if (ecall_i) begin
        csr_wdata_o = rv_exec_pkg::CAUSE_ECALL_M;
      end else if (mret_i) begin
        csr_wdata_o = csr_rdata_i | MPIE_MASK;
      end else begin
        case (funct3_i)
          rv_exec_pkg::F3_CSRRW, rv_exec_pkg::F3_CSRRWI: csr_wdata_o = src1_i;
          rv_exec_pkg::F3_CSRRS, rv_exec_pkg::F3_CSRRSI: csr_wdata_o = csr_rdata_i | src1_i;
          rv_exec_pkg::F3_CSRRC, rv_exec_pkg::F3_CSRRCI: csr_wdata_o = csr_rdata_i & ~src1_i;
          default: csr_wdata_o = '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: design/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
  input  wire rv_exec_pkg::word_t   src1_i,
  input  wire rv_exec_pkg::word_t   src2_i,
  input  wire rv_exec_pkg::alu_op_e op_i,
  output rv_exec_pkg::word_t        res_o
);

  logic [4:0] shamt;

  assign shamt = src2_i[4:0];  // RV32 shift range.

  always_comb begin
    case (op_i)
      rv_exec_pkg::ALU_ADD: begin
        res_o = src1_i + src2_i;
      end
      rv_exec_pkg::ALU_SUB: begin
        res_o = src1_i - src2_i;
      end
      rv_exec_pkg::ALU_SLL: begin
        res_o = src1_i << shamt;
      end
      rv_exec_pkg::ALU_SLT: begin
        res_o = rv_exec_pkg::word_t'($signed(src1_i) < $signed(src2_i));
      end
      rv_exec_pkg::ALU_SLTU: begin
        res_o = rv_exec_pkg::word_t'(src1_i < src2_i);
      end
      rv_exec_pkg::ALU_XOR: begin
        res_o = src1_i ^ src2_i;
      end
      rv_exec_pkg::ALU_SRL: begin
        res_o = src1_i >> shamt;
      end
      rv_exec_pkg::ALU_SRA: begin
        res_o = $signed(src1_i) >>> shamt;  // Keeps the sign bit.
      end
      rv_exec_pkg::ALU_OR: begin
        res_o = src1_i | src2_i;
      end
      rv_exec_pkg::ALU_AND: begin
        res_o = src1_i & src2_i;
      end
      rv_exec_pkg::ALU_SLE: begin
        res_o = rv_exec_pkg::word_t'($signed(src1_i) <= $signed(src2_i));
      end
      rv_exec_pkg::ALU_SLEU: begin
        res_o = rv_exec_pkg::word_t'(src1_i <= src2_i);
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     inst_t;
  typedef logic [3:0]      reg_idx_t;  // RV32E register file.
  typedef logic [11:0]     csr_addr_t;

  // ####################
  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_SLE  = 4'd10,
    ALU_SLEU = 4'd11
  } alu_op_e;

  // ####################
  // CSR instruction funct3 and addresses
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  localparam word_t CAUSE_ECALL_M = 32'h0000_000B;  // Environment call from M-mode.

  typedef enum logic {
    IDLE,
    WAIT_MEM
  } exu_state_e;

endpackage

`default_nettype wire
